// File: common/jesd_tx_regs_pkg.sv
// ********************
// JESD204 transmit register map package
// Address map, identification constants and field types
// shared by the bridge and the register blocks
// ********************

package jesd_tx_regs_pkg;

  localparam int num_lanes = 4;
  localparam int axi_addr_w = 14;

  localparam logic [31:0] core_id = 32'h0000_0000;
  localparam logic [31:0] pcore_version = 32'h0001_0661;
  localparam logic [31:0] pcore_magic = 32'h3230_3454;

  localparam logic [1:0] resp_okay = 2'b00;

  typedef logic [11:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;
  typedef logic [9:0] octets_mf_t;
  typedef logic [7:0] octets_f_t;
  typedef logic [num_lanes-1:0] lane_mask_t;

  // ********************
  // Word addresses on the register bus

  // Common block
  localparam reg_addr_t addr_version = 12'h000;
  localparam reg_addr_t addr_id = 12'h001;
  localparam reg_addr_t addr_scratch = 12'h002;
  localparam reg_addr_t addr_magic = 12'h003;
  localparam reg_addr_t addr_irq_enable = 12'h010;
  localparam reg_addr_t addr_irq_pending = 12'h011;
  localparam reg_addr_t addr_link_disable = 12'h030;
  localparam reg_addr_t addr_lanes_disable = 12'h080;
  localparam reg_addr_t addr_link_conf0 = 12'h082;
  localparam reg_addr_t addr_link_conf1 = 12'h084;

  // SYSREF block
  localparam reg_addr_t addr_sysref_conf = 12'h040;
  localparam reg_addr_t addr_lmfc_offset = 12'h041;
  localparam reg_addr_t addr_sysref_status = 12'h042;

  // Transmit block
  localparam reg_addr_t addr_ilas_conf = 12'h090;
  localparam reg_addr_t addr_manual_sync = 12'h0a0;
  localparam reg_addr_t addr_link_status = 12'h0a1;

endpackage

// File: verilog/axi_reg_bridge.sv
// ********************
// AXI4-Lite to register bus bridge
// Runs one transaction at a time, issues single-cycle register
// requests and registers the merged read data
// ********************

`timescale 1ns/100ps

module axi_reg_bridge
  import jesd_tx_regs_pkg::*;
(
  input  logic                  s_axi_aclk,
  input  logic                  rst_n,

  input  logic                  awvalid,
  input  logic [axi_addr_w-1:0] awaddr,
  output logic                  awready,
  input  logic                  wvalid,
  input  reg_data_t             wdata,
  output logic                  wready,
  output logic                  bvalid,
  output logic [1:0]            bresp,
  input  logic                  bready,
  input  logic                  arvalid,
  input  logic [axi_addr_w-1:0] araddr,
  output logic                  arready,
  output logic                  rvalid,
  output logic [1:0]            rresp,
  output reg_data_t             rdata,
  input  logic                  rready,

  output logic                  up_wreq,
  output reg_addr_t             up_waddr,
  output reg_data_t             up_wdata,
  output reg_addr_t             up_raddr,
  input  reg_data_t             rdata_common,
  input  reg_data_t             rdata_sysref,
  input  reg_data_t             rdata_tx
);

  typedef enum logic [2:0] {
    st_idle,
    st_write,
    st_wresp,
    st_read,
    st_rresp
  } bridge_state_t;

  bridge_state_t state;
  bridge_state_t state_next;
  logic wr_go;
  logic rd_go;

  // A write with both address and data present wins over a read
  assign wr_go = (state == st_idle) && awvalid && wvalid;
  assign rd_go = (state == st_idle) && arvalid && !(awvalid && wvalid);

  assign awready = wr_go;
  assign wready = wr_go;
  assign arready = rd_go;
  assign bvalid = (state == st_wresp);
  assign rvalid = (state == st_rresp);
  assign bresp = resp_okay;
  assign rresp = resp_okay;
  assign up_wreq = (state == st_write);

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (wr_go) begin
          state_next = st_write;
        end else if (rd_go) begin
          state_next = st_read;
        end
      end
      st_write: state_next = st_wresp;
      st_wresp: begin
        if (bready) begin
          state_next = st_idle;
        end
      end
      st_read: state_next = st_rresp;
      st_rresp: begin
        if (rready) begin
          state_next = st_idle;
        end
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge s_axi_aclk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (wr_go) begin
      up_waddr <= awaddr[axi_addr_w-1:2];
      up_wdata <= wdata;
    end
    if (rd_go) begin
      up_raddr <= araddr[axi_addr_w-1:2];
    end
    // Blocks answer for unowned addresses with zero, so OR is enough
    if (state == st_read) begin
      rdata <= rdata_common | rdata_sysref | rdata_tx;
    end
  end

  assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    !(bvalid && rvalid));

  assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    up_wreq |=> !up_wreq);

endmodule

// File: verilog/link_cfg_regs.sv
// ********************
// Common link registers
// Identification, scratch, link enable and reset, the locked
// link configuration and the masked interrupt
// ********************

`timescale 1ns/100ps

module link_cfg_regs
  import jesd_tx_regs_pkg::*;
(
  input  logic       s_axi_aclk,
  input  logic       rst_n,
  input  logic       up_wreq,
  input  reg_addr_t  up_waddr,
  input  reg_data_t  up_wdata,
  input  reg_addr_t  up_raddr,
  input  logic       irq_trigger,
  output reg_data_t  rdata,
  output logic       irq,
  output logic       cfg_writeable,
  output logic       core_reset,
  output lane_mask_t lanes_disable,
  output octets_f_t  octets_per_frame,
  output octets_mf_t octets_per_multiframe,
  output logic       disable_scrambler,
  output logic       disable_char_replacement
);

  reg_data_t scratch;
  logic link_disable;
  logic irq_enable;
  logic irq_pending;
  logic pending_clr;

  // The link is held in reset and may be reconfigured while disabled
  assign core_reset = link_disable;
  assign cfg_writeable = link_disable;

  always_ff @(posedge s_axi_aclk) begin
    if (!rst_n) begin
      scratch <= '0;
      link_disable <= 1'b1;
      irq_enable <= 1'b0;
      lanes_disable <= '0;
      octets_per_frame <= '0;
      octets_per_multiframe <= '0;
      disable_scrambler <= 1'b0;
      disable_char_replacement <= 1'b0;
    end else if (up_wreq) begin
      case (up_waddr)
        addr_scratch: scratch <= up_wdata;
        addr_irq_enable: irq_enable <= up_wdata[0];
        addr_link_disable: link_disable <= up_wdata[0];
        addr_lanes_disable: begin
          if (cfg_writeable) begin
            lanes_disable <= up_wdata[num_lanes-1:0];
          end
        end
        addr_link_conf0: begin
          if (cfg_writeable) begin
            octets_per_frame <= up_wdata[7:0];
            octets_per_multiframe <= up_wdata[25:16];
          end
        end
        addr_link_conf1: begin
          if (cfg_writeable) begin
            disable_scrambler <= up_wdata[0];
            disable_char_replacement <= up_wdata[1];
          end
        end
        default: ;
      endcase
    end
  end

  // ********************
  // Interrupt

  assign pending_clr = up_wreq && (up_waddr == addr_irq_pending) && up_wdata[0];

  always_ff @(posedge s_axi_aclk) begin
    if (!rst_n) begin
      irq_pending <= 1'b0;
      irq <= 1'b0;
    end else begin
      irq_pending <= (irq_pending & ~pending_clr) | irq_trigger;
      irq <= irq_pending & irq_enable;
    end
  end

  always_comb begin
    rdata = '0;
    case (up_raddr)
      addr_version: rdata = pcore_version;
      addr_id: rdata = core_id;
      addr_scratch: rdata = scratch;
      addr_magic: rdata = pcore_magic;
      addr_irq_enable: rdata = {31'd0, irq_enable};
      addr_irq_pending: rdata = {31'd0, irq_pending};
      addr_link_disable: rdata = {31'd0, link_disable};
      addr_lanes_disable: rdata = reg_data_t'(lanes_disable);
      addr_link_conf0: rdata = {6'd0, octets_per_multiframe, 8'd0, octets_per_frame};
      addr_link_conf1: rdata = {30'd0, disable_char_replacement, disable_scrambler};
      default: rdata = '0;
    endcase
  end

  assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    !cfg_writeable |=> $stable({lanes_disable, octets_per_frame, octets_per_multiframe,
                                disable_scrambler, disable_char_replacement}));

endmodule

// File: verilog/sysref_regs.sv
// ********************
// SYSREF registers
// Locked SYSREF configuration and sticky SYSREF event status
// ********************

`timescale 1ns/100ps

module sysref_regs
  import jesd_tx_regs_pkg::*;
(
  input  logic      s_axi_aclk,
  input  logic      rst_n,
  input  logic      up_wreq,
  input  reg_addr_t up_waddr,
  input  reg_data_t up_wdata,
  input  reg_addr_t up_raddr,
  input  logic      cfg_writeable,
  input  logic      sysref_edge,
  input  logic      sysref_alignment_error,
  output reg_data_t rdata,
  output logic [7:0] lmfc_offset,
  output logic      sysref_oneshot,
  output logic      sysref_disable,
  output logic      irq_trigger
);

  // Bit 0 is the edge seen flag, bit 1 the alignment error flag
  logic [1:0] sysref_status;
  logic [1:0] status_clr;
  logic [1:0] status_next;

  always_ff @(posedge s_axi_aclk) begin
    if (!rst_n) begin
      lmfc_offset <= '0;
      sysref_oneshot <= 1'b0;
      sysref_disable <= 1'b0;
    end else if (up_wreq && cfg_writeable) begin
      if (up_waddr == addr_sysref_conf) begin
        sysref_disable <= up_wdata[0];
        sysref_oneshot <= up_wdata[1];
      end
      if (up_waddr == addr_lmfc_offset) begin
        lmfc_offset <= up_wdata[7:0];
      end
    end
  end

  // A new event overrides a clear in the same cycle
  assign status_clr = (up_wreq && (up_waddr == addr_sysref_status)) ? up_wdata[1:0] : 2'b00;
  assign status_next = (sysref_status & ~status_clr) | {sysref_alignment_error, sysref_edge};

  always_ff @(posedge s_axi_aclk) begin
    if (!rst_n) begin
      sysref_status <= 2'b00;
      irq_trigger <= 1'b0;
    end else begin
      sysref_status <= status_next;
      irq_trigger <= status_next[1] & ~sysref_status[1];
    end
  end

  always_comb begin
    rdata = '0;
    case (up_raddr)
      addr_sysref_conf: rdata = {30'd0, sysref_oneshot, sysref_disable};
      addr_lmfc_offset: rdata = {24'd0, lmfc_offset};
      addr_sysref_status: rdata = {30'd0, sysref_status};
      default: rdata = '0;
    endcase
  end

endmodule

// File: verilog/tx_link_regs.sv
// ********************
// Transmit link registers
// ILAS controls, manual SYNC request and link status readback
// ********************

`timescale 1ns/100ps

module tx_link_regs
  import jesd_tx_regs_pkg::*;
(
  input  logic       s_axi_aclk,
  input  logic       rst_n,
  input  logic       up_wreq,
  input  reg_addr_t  up_waddr,
  input  reg_data_t  up_wdata,
  input  reg_addr_t  up_raddr,
  input  logic       cfg_writeable,
  input  logic [1:0] status_state,
  input  logic       status_sync,
  output reg_data_t  rdata,
  output logic [7:0] mframes_per_ilas,
  output logic       skip_ilas,
  output logic       continuous_ilas,
  output logic       continuous_cgs,
  output logic       manual_sync_request
);

  logic sync_req_wr;

  always_ff @(posedge s_axi_aclk) begin
    if (!rst_n) begin
      mframes_per_ilas <= '0;
      skip_ilas <= 1'b0;
      continuous_ilas <= 1'b0;
      continuous_cgs <= 1'b0;
    end else if (up_wreq && cfg_writeable && (up_waddr == addr_ilas_conf)) begin
      mframes_per_ilas <= up_wdata[7:0];
      skip_ilas <= up_wdata[8];
      continuous_ilas <= up_wdata[9];
      continuous_cgs <= up_wdata[10];
    end
  end

  // ********************
  // Manual SYNC request, one cycle after the register write

  assign sync_req_wr = up_wreq && (up_waddr == addr_manual_sync) && up_wdata[0];

  always_ff @(posedge s_axi_aclk) begin
    if (!rst_n) begin
      manual_sync_request <= 1'b0;
    end else begin
      manual_sync_request <= sync_req_wr;
    end
  end

  always_comb begin
    rdata = '0;
    case (up_raddr)
      addr_ilas_conf: begin
        rdata = {21'd0, continuous_cgs, continuous_ilas, skip_ilas, mframes_per_ilas};
      end
      addr_link_status: rdata = {27'd0, status_sync, 2'd0, status_state};
      default: rdata = '0;
    endcase
  end

endmodule

// File: verilog/jesd_tx_reg_map.sv
// ********************
// JESD204 transmit register map
// AXI4-Lite slave with the common, SYSREF and transmit blocks
// ********************

`timescale 1ns/100ps

module jesd_tx_reg_map
  import jesd_tx_regs_pkg::*;
(
  input  logic                  s_axi_aclk,
  input  logic                  rst_n,

  input  logic                  s_axi_awvalid,
  input  logic [axi_addr_w-1:0] s_axi_awaddr,
  output logic                  s_axi_awready,
  input  logic                  s_axi_wvalid,
  input  reg_data_t             s_axi_wdata,
  output logic                  s_axi_wready,
  output logic                  s_axi_bvalid,
  output logic [1:0]            s_axi_bresp,
  input  logic                  s_axi_bready,
  input  logic                  s_axi_arvalid,
  input  logic [axi_addr_w-1:0] s_axi_araddr,
  output logic                  s_axi_arready,
  output logic                  s_axi_rvalid,
  output logic [1:0]            s_axi_rresp,
  output reg_data_t             s_axi_rdata,
  input  logic                  s_axi_rready,

  output logic                  irq,
  output logic                  core_reset,

  output lane_mask_t            lanes_disable,
  output octets_f_t             octets_per_frame,
  output octets_mf_t            octets_per_multiframe,
  output logic                  disable_scrambler,
  output logic                  disable_char_replacement,
  output logic [7:0]            lmfc_offset,
  output logic                  sysref_oneshot,
  output logic                  sysref_disable,
  output logic [7:0]            mframes_per_ilas,
  output logic                  skip_ilas,
  output logic                  continuous_ilas,
  output logic                  continuous_cgs,
  output logic                  manual_sync_request,

  input  logic                  sysref_edge,
  input  logic                  sysref_alignment_error,
  input  logic [1:0]            status_state,
  input  logic                  status_sync
);

  logic up_wreq;
  reg_addr_t up_waddr;
  reg_data_t up_wdata;
  reg_addr_t up_raddr;
  reg_data_t rdata_common;
  reg_data_t rdata_sysref;
  reg_data_t rdata_tx;
  logic cfg_writeable;
  logic irq_trigger;

  axi_reg_bridge i_bridge (
    .s_axi_aclk   (s_axi_aclk),
    .rst_n        (rst_n),
    .awvalid      (s_axi_awvalid),
    .awaddr       (s_axi_awaddr),
    .awready      (s_axi_awready),
    .wvalid       (s_axi_wvalid),
    .wdata        (s_axi_wdata),
    .wready       (s_axi_wready),
    .bvalid       (s_axi_bvalid),
    .bresp        (s_axi_bresp),
    .bready       (s_axi_bready),
    .arvalid      (s_axi_arvalid),
    .araddr       (s_axi_araddr),
    .arready      (s_axi_arready),
    .rvalid       (s_axi_rvalid),
    .rresp        (s_axi_rresp),
    .rdata        (s_axi_rdata),
    .rready       (s_axi_rready),
    .up_wreq      (up_wreq),
    .up_waddr     (up_waddr),
    .up_wdata     (up_wdata),
    .up_raddr     (up_raddr),
    .rdata_common (rdata_common),
    .rdata_sysref (rdata_sysref),
    .rdata_tx     (rdata_tx)
  );

  link_cfg_regs i_link_cfg (
    .s_axi_aclk               (s_axi_aclk),
    .rst_n                    (rst_n),
    .up_wreq                  (up_wreq),
    .up_waddr                 (up_waddr),
    .up_wdata                 (up_wdata),
    .up_raddr                 (up_raddr),
    .irq_trigger              (irq_trigger),
    .rdata                    (rdata_common),
    .irq                      (irq),
    .cfg_writeable            (cfg_writeable),
    .core_reset               (core_reset),
    .lanes_disable            (lanes_disable),
    .octets_per_frame         (octets_per_frame),
    .octets_per_multiframe    (octets_per_multiframe),
    .disable_scrambler        (disable_scrambler),
    .disable_char_replacement (disable_char_replacement)
  );

  sysref_regs i_sysref (
    .s_axi_aclk             (s_axi_aclk),
    .rst_n                  (rst_n),
    .up_wreq                (up_wreq),
    .up_waddr               (up_waddr),
    .up_wdata               (up_wdata),
    .up_raddr               (up_raddr),
    .cfg_writeable          (cfg_writeable),
    .sysref_edge            (sysref_edge),
    .sysref_alignment_error (sysref_alignment_error),
    .rdata                  (rdata_sysref),
    .lmfc_offset            (lmfc_offset),
    .sysref_oneshot         (sysref_oneshot),
    .sysref_disable         (sysref_disable),
    .irq_trigger            (irq_trigger)
  );

  tx_link_regs i_tx_link (
    .s_axi_aclk          (s_axi_aclk),
    .rst_n               (rst_n),
    .up_wreq             (up_wreq),
    .up_waddr            (up_waddr),
    .up_wdata            (up_wdata),
    .up_raddr            (up_raddr),
    .cfg_writeable       (cfg_writeable),
    .status_state        (status_state),
    .status_sync         (status_sync),
    .rdata               (rdata_tx),
    .mframes_per_ilas    (mframes_per_ilas),
    .skip_ilas           (skip_ilas),
    .continuous_ilas     (continuous_ilas),
    .continuous_cgs      (continuous_cgs),
    .manual_sync_request (manual_sync_request)
  );

endmodule

// File: verification/jesd_tx_reg_map_tb.sv
// ********************
// Testbench for the JESD204 transmit register map
// Directed AXI4-Lite tests of the common, SYSREF and transmit blocks
// ********************

`timescale 1ns/100ps

module jesd_tx_reg_map_tb
  import jesd_tx_regs_pkg::*;
();

  localparam int timeout_cycles = 100;
  localparam int wait_aw = 0;
  localparam int wait_b = 1;
  localparam int wait_ar = 2;
  localparam int wait_r = 3;
  localparam int wait_irq_high = 4;
  localparam int wait_irq_low = 5;

  logic s_axi_aclk;
  logic rst_n;
  logic awvalid;
  logic [axi_addr_w-1:0] awaddr;
  logic awready;
  logic wvalid;
  reg_data_t wdata;
  logic wready;
  logic bvalid;
  logic [1:0] bresp;
  logic bready;
  logic arvalid;
  logic [axi_addr_w-1:0] araddr;
  logic arready;
  logic rvalid;
  logic [1:0] rresp;
  reg_data_t rdata;
  logic rready;
  logic irq;
  logic core_reset;
  lane_mask_t lanes_disable;
  octets_f_t octets_per_frame;
  octets_mf_t octets_per_multiframe;
  logic disable_scrambler;
  logic disable_char_replacement;
  logic [7:0] lmfc_offset;
  logic sysref_oneshot;
  logic sysref_disable;
  logic [7:0] mframes_per_ilas;
  logic skip_ilas;
  logic continuous_ilas;
  logic continuous_cgs;
  logic manual_sync_request;
  logic sysref_edge;
  logic sysref_alignment_error;
  logic [1:0] status_state;
  logic status_sync;

  integer seed;
  int mismatches = 0;
  int failures = 0;
  int sync_pulses = 0;
  int sync_in_resp = 0;
  string test_name;
  reg_data_t exp_lanes;
  reg_data_t exp_conf0;
  reg_data_t exp_conf1;
  reg_data_t exp_ilas;
  reg_data_t exp_lmfc;
  reg_data_t exp_sysref;

  jesd_tx_reg_map DUT (
    .s_axi_aclk               (s_axi_aclk),
    .rst_n                    (rst_n),
    .s_axi_awvalid            (awvalid),
    .s_axi_awaddr             (awaddr),
    .s_axi_awready            (awready),
    .s_axi_wvalid             (wvalid),
    .s_axi_wdata              (wdata),
    .s_axi_wready             (wready),
    .s_axi_bvalid             (bvalid),
    .s_axi_bresp              (bresp),
    .s_axi_bready             (bready),
    .s_axi_arvalid            (arvalid),
    .s_axi_araddr             (araddr),
    .s_axi_arready            (arready),
    .s_axi_rvalid             (rvalid),
    .s_axi_rresp              (rresp),
    .s_axi_rdata              (rdata),
    .s_axi_rready             (rready),
    .irq                      (irq),
    .core_reset               (core_reset),
    .lanes_disable            (lanes_disable),
    .octets_per_frame         (octets_per_frame),
    .octets_per_multiframe    (octets_per_multiframe),
    .disable_scrambler        (disable_scrambler),
    .disable_char_replacement (disable_char_replacement),
    .lmfc_offset              (lmfc_offset),
    .sysref_oneshot           (sysref_oneshot),
    .sysref_disable           (sysref_disable),
    .mframes_per_ilas         (mframes_per_ilas),
    .skip_ilas                (skip_ilas),
    .continuous_ilas          (continuous_ilas),
    .continuous_cgs           (continuous_cgs),
    .manual_sync_request      (manual_sync_request),
    .sysref_edge              (sysref_edge),
    .sysref_alignment_error   (sysref_alignment_error),
    .status_state             (status_state),
    .status_sync              (status_sync)
  );

  initial begin
    s_axi_aclk = 1'b0;
    forever #4 s_axi_aclk = ~s_axi_aclk;
  end

  // Counts SYNC request cycles, and those that fall in the write response cycle
  always @(negedge s_axi_aclk) begin
    if (manual_sync_request) begin
      sync_pulses = sync_pulses + 1;
      if (bvalid) begin
        sync_in_resp = sync_in_resp + 1;
      end
    end
  end

  task report_mismatch(input reg_data_t expected, input reg_data_t actual);
    mismatches++;
    $display("MISMATCH %s expected 0x%08h actual 0x%08h", test_name, expected, actual);
  endtask

  task report_failure(input string what);
    failures++;
    $display("ERROR in %s: %s", test_name, what);
  endtask

  function automatic logic handshake_seen(input int kind);
    case (kind)
      wait_aw: return awready && wready;
      wait_b: return bvalid;
      wait_ar: return arready;
      wait_r: return rvalid;
      wait_irq_high: return irq;
      default: return !irq;
    endcase
  endfunction

  task wait_handshake(input int kind, input string what);
    int cnt;
    cnt = 0;
    @(negedge s_axi_aclk);
    while (!handshake_seen(kind) && cnt < timeout_cycles) begin
      @(negedge s_axi_aclk);
      cnt++;
    end
    if (!handshake_seen(kind)) begin
      report_failure(what);
    end
  endtask

  task axi_write(input reg_addr_t addr, input reg_data_t data);
    @(posedge s_axi_aclk);
    awvalid <= 1'b1;
    awaddr <= {addr, 2'b00};
    wvalid <= 1'b1;
    wdata <= data;
    wait_handshake(wait_aw, "write address and data were never accepted");
    @(posedge s_axi_aclk);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    bready <= 1'b1;
    wait_handshake(wait_b, "no write response arrived");
    if (bresp !== resp_okay) begin
      report_mismatch({30'd0, resp_okay}, {30'd0, bresp});
    end
    @(posedge s_axi_aclk);
    bready <= 1'b0;
  endtask

  task axi_read(input reg_addr_t addr, output reg_data_t data);
    @(posedge s_axi_aclk);
    arvalid <= 1'b1;
    araddr <= {addr, 2'b00};
    wait_handshake(wait_ar, "read address was never accepted");
    @(posedge s_axi_aclk);
    arvalid <= 1'b0;
    rready <= 1'b1;
    wait_handshake(wait_r, "no read data arrived");
    data = rdata;
    if (rresp !== resp_okay) begin
      report_mismatch({30'd0, resp_okay}, {30'd0, rresp});
    end
    @(posedge s_axi_aclk);
    rready <= 1'b0;
  endtask

  task check_read(input reg_addr_t addr, input reg_data_t expected);
    reg_data_t rd;
    axi_read(addr, rd);
    if (rd !== expected) begin
      report_mismatch(expected, rd);
    end
  endtask

  task pulse_sysref(input logic edge_in, input logic error_in);
    @(posedge s_axi_aclk);
    sysref_edge <= edge_in;
    sysref_alignment_error <= error_in;
    @(posedge s_axi_aclk);
    sysref_edge <= 1'b0;
    sysref_alignment_error <= 1'b0;
  endtask

  // Without an update every field gets the inverse of its expected value
  task write_locked_regs(input logic update_expected);
    reg_data_t wr;
    wr = update_expected ? $random(seed) : ~exp_lanes;
    axi_write(addr_lanes_disable, wr);
    if (update_expected) exp_lanes = wr & 32'h0000_000f;
    wr = update_expected ? $random(seed) : ~exp_conf0;
    axi_write(addr_link_conf0, wr);
    if (update_expected) exp_conf0 = wr & 32'h03ff_00ff;
    wr = update_expected ? $random(seed) : ~exp_conf1;
    axi_write(addr_link_conf1, wr);
    if (update_expected) exp_conf1 = wr & 32'h0000_0003;
    wr = update_expected ? $random(seed) : ~exp_ilas;
    axi_write(addr_ilas_conf, wr);
    if (update_expected) exp_ilas = wr & 32'h0000_07ff;
    wr = update_expected ? $random(seed) : ~exp_lmfc;
    axi_write(addr_lmfc_offset, wr);
    if (update_expected) exp_lmfc = wr & 32'h0000_00ff;
    wr = update_expected ? $random(seed) : ~exp_sysref;
    axi_write(addr_sysref_conf, wr);
    if (update_expected) exp_sysref = wr & 32'h0000_0003;
  endtask

  task check_config();
    reg_data_t act;
    check_read(addr_lanes_disable, exp_lanes);
    check_read(addr_link_conf0, exp_conf0);
    check_read(addr_link_conf1, exp_conf1);
    check_read(addr_ilas_conf, exp_ilas);
    check_read(addr_lmfc_offset, exp_lmfc);
    check_read(addr_sysref_conf, exp_sysref);
    @(negedge s_axi_aclk);
    act = {28'd0, lanes_disable};
    if (act !== exp_lanes) report_mismatch(exp_lanes, act);
    act = {6'd0, octets_per_multiframe, 8'd0, octets_per_frame};
    if (act !== exp_conf0) report_mismatch(exp_conf0, act);
    act = {30'd0, disable_char_replacement, disable_scrambler};
    if (act !== exp_conf1) report_mismatch(exp_conf1, act);
    act = {21'd0, continuous_cgs, continuous_ilas, skip_ilas, mframes_per_ilas};
    if (act !== exp_ilas) report_mismatch(exp_ilas, act);
    act = {24'd0, lmfc_offset};
    if (act !== exp_lmfc) report_mismatch(exp_lmfc, act);
    act = {30'd0, sysref_oneshot, sysref_disable};
    if (act !== exp_sysref) report_mismatch(exp_sysref, act);
  endtask

  // ********************
  // Test tasks

  task test_reset_id();
    reg_data_t wr;
    test_name = "reset_id";
    @(negedge s_axi_aclk);
    if (core_reset !== 1'b1) report_mismatch(32'd1, {31'd0, core_reset});
    if (irq !== 1'b0) report_mismatch(32'd0, {31'd0, irq});
    if ({awready, wready, bvalid, arready, rvalid} !== 5'd0) begin
      report_failure("a ready or valid output is high after reset");
    end
    check_read(addr_version, pcore_version);
    check_read(addr_id, core_id);
    check_read(addr_magic, pcore_magic);
    check_read(12'h3fc, 32'd0);
    repeat (4) begin
      wr = $random(seed);
      axi_write(addr_scratch, wr);
      check_read(addr_scratch, wr);
    end
  endtask

  task test_locked_config();
    test_name = "locked_config";
    write_locked_regs(1'b1);
    check_config();
  endtask

  task test_config_lock();
    reg_data_t wr;
    test_name = "config_lock";
    axi_write(addr_link_disable, 32'd0);
    check_read(addr_link_disable, 32'd0);
    @(negedge s_axi_aclk);
    if (core_reset !== 1'b0) report_mismatch(32'd0, {31'd0, core_reset});
    // Link enabled, so every locked write must be ignored
    write_locked_regs(1'b0);
    check_config();
    axi_write(addr_link_disable, 32'd1);
    @(negedge s_axi_aclk);
    if (core_reset !== 1'b1) report_mismatch(32'd1, {31'd0, core_reset});
    wr = $random(seed);
    axi_write(addr_lanes_disable, wr);
    exp_lanes = wr & 32'h0000_000f;
    check_config();
  endtask

  task test_sysref_irq();
    test_name = "sysref_irq";
    axi_write(addr_irq_enable, 32'd1);
    pulse_sysref(1'b1, 1'b0);
    check_read(addr_sysref_status, 32'd1);
    @(negedge s_axi_aclk);
    if (irq !== 1'b0) report_mismatch(32'd0, {31'd0, irq});
    pulse_sysref(1'b0, 1'b1);
    wait_handshake(wait_irq_high, "irq did not rise after an alignment error");
    check_read(addr_sysref_status, 32'd3);
    check_read(addr_irq_pending, 32'd1);
    axi_write(addr_sysref_status, 32'd3);
    check_read(addr_sysref_status, 32'd0);
    axi_write(addr_irq_pending, 32'd1);
    wait_handshake(wait_irq_low, "irq did not fall after the pending bit was cleared");
    check_read(addr_irq_pending, 32'd0);
    axi_write(addr_irq_enable, 32'd0);
    pulse_sysref(1'b0, 1'b1);
    repeat (5) begin
      @(negedge s_axi_aclk);
      if (irq !== 1'b0) report_mismatch(32'd0, {31'd0, irq});
    end
    check_read(addr_irq_pending, 32'd1);
    axi_write(addr_sysref_status, 32'd3);
    axi_write(addr_irq_pending, 32'd1);
  endtask

  task test_manual_sync();
    int start_pulses;
    int start_resp;
    test_name = "manual_sync";
    start_pulses = sync_pulses;
    start_resp = sync_in_resp;
    axi_write(addr_manual_sync, 32'd1);
    repeat (4) @(posedge s_axi_aclk);
    if (sync_pulses - start_pulses != 1) begin
      report_mismatch(32'd1, reg_data_t'(sync_pulses - start_pulses));
    end
    // The pulse follows up_wreq, which is the first write response cycle
    if (sync_in_resp - start_resp != 1) begin
      report_failure("manual_sync_request was not high in the write response cycle");
    end
    status_state <= 2'b10;
    status_sync <= 1'b1;
    check_read(addr_link_status, 32'h0000_0012);
    status_state <= 2'b01;
    status_sync <= 1'b0;
    check_read(addr_link_status, 32'h0000_0001);
  endtask

  task test_backpressure();
    reg_data_t wr;
    reg_data_t wr2;
    reg_data_t held;
    test_name = "backpressure";
    wr = $random(seed);
    wr2 = $random(seed);
    @(posedge s_axi_aclk);
    awvalid <= 1'b1;
    awaddr <= {addr_scratch, 2'b00};
    wvalid <= 1'b1;
    wdata <= wr;
    wait_handshake(wait_aw, "write address and data were never accepted");
    @(posedge s_axi_aclk);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    arvalid <= 1'b1;
    araddr <= {addr_scratch, 2'b00};
    wait_handshake(wait_b, "no write response arrived");
    repeat (5) begin
      @(negedge s_axi_aclk);
      if (!bvalid) report_failure("bvalid dropped before bready");
      if (arready) report_failure("a read was accepted during a pending write response");
    end
    @(posedge s_axi_aclk);
    bready <= 1'b1;
    @(posedge s_axi_aclk);
    bready <= 1'b0;
    wait_handshake(wait_ar, "read address was never accepted");
    @(posedge s_axi_aclk);
    arvalid <= 1'b0;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    wdata <= wr2;
    wait_handshake(wait_r, "no read data arrived");
    held = rdata;
    if (held !== wr) report_mismatch(wr, held);
    repeat (5) begin
      @(negedge s_axi_aclk);
      if (!rvalid) report_failure("rvalid dropped before rready");
      if (rdata !== held) report_mismatch(held, rdata);
      if (awready) report_failure("a write was accepted during a pending read response");
    end
    @(posedge s_axi_aclk);
    rready <= 1'b1;
    @(posedge s_axi_aclk);
    rready <= 1'b0;
    wait_handshake(wait_aw, "second write was never accepted");
    @(posedge s_axi_aclk);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    bready <= 1'b1;
    wait_handshake(wait_b, "no write response arrived");
    @(posedge s_axi_aclk);
    bready <= 1'b0;
    check_read(addr_scratch, wr2);
  endtask

  initial begin
    seed = 32'hdd5f_90c3;
    test_name = "reset";
    rst_n <= 1'b0;
    awvalid <= 1'b0;
    awaddr <= '0;
    wvalid <= 1'b0;
    wdata <= '0;
    bready <= 1'b0;
    arvalid <= 1'b0;
    araddr <= '0;
    rready <= 1'b0;
    sysref_edge <= 1'b0;
    sysref_alignment_error <= 1'b0;
    status_state <= 2'b00;
    status_sync <= 1'b0;
    repeat (4) @(posedge s_axi_aclk);
    rst_n <= 1'b1;

    test_reset_id();
    test_locked_config();
    test_config_lock();
    test_sysref_irq();
    test_manual_sync();
    test_backpressure();

    repeat (2) @(posedge s_axi_aclk);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
common/jesd_tx_regs_pkg.sv
verilog/axi_reg_bridge.sv
verilog/link_cfg_regs.sv
verilog/sysref_regs.sv
verilog/tx_link_regs.sv
verilog/jesd_tx_reg_map.sv
verification/jesd_tx_reg_map_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the register map testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f list.f --top-module jesd_tx_reg_map_tb -Mdir obj_dir -o jesd_tx_sim \
  && ./obj_dir/jesd_tx_sim > sim.log 2>&1 \
  || echo "Build or simulation returned an error"

grep -qx "Test OK" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
